// ==== logic/exu_pkg.sv ====
/*
 * shared definitions for the RV32I execute unit
 *   data and shift-amount widths
 *   operand, immediate and funct3 vector types
 *   instruction class, ALU code and branch condition enums
 *   funct3 codes for the integer and branch groups
 *   handshake FSM state encodings
 */
package exu_pkg;

	// data path width
	localparam int xlen = 32;
	// only the low bits of src2 move a shift
	localparam int shamt_bits = 5;

	typedef logic [xlen-1:0] word_t;
	typedef logic [2:0] funct3_t;

	// which operand format the operation uses
	typedef enum logic [1:0] {
		cls_reg = 2'd0,
		cls_imm = 2'd1,
		cls_lui = 2'd2,
		cls_branch = 2'd3
	} op_class_e;

	// ALU control, gaps are codes of the old unmasked shifts
	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_slt = 4'd3,
		alu_sltu = 4'd4,
		alu_xor = 4'd5,
		alu_or = 4'd8,
		alu_and = 4'd9,
		alu_pass = 4'd10,
		alu_srl = 4'd11,
		alu_sll = 4'd12,
		alu_sra = 4'd13
	} alu_op_e;

	typedef enum logic [2:0] {
		br_none,
		br_eq,
		br_ne,
		br_lt,
		br_ge,
		br_ltu,
		br_geu
	} br_cond_e;

	// integer op group, shared by register and immediate classes
	localparam funct3_t f3_add_sub = 3'd0;
	localparam funct3_t f3_sll = 3'd1;
	localparam funct3_t f3_slt = 3'd2;
	localparam funct3_t f3_sltu = 3'd3;
	localparam funct3_t f3_xor = 3'd4;
	localparam funct3_t f3_srl_sra = 3'd5;
	localparam funct3_t f3_or = 3'd6;
	localparam funct3_t f3_and = 3'd7;

	// branch group
	localparam funct3_t f3_beq = 3'd0;
	localparam funct3_t f3_bne = 3'd1;
	localparam funct3_t f3_blt = 3'd4;
	localparam funct3_t f3_bge = 3'd5;
	localparam funct3_t f3_bltu = 3'd6;
	localparam funct3_t f3_bgeu = 3'd7;

	typedef enum logic [1:0] {rx_idle, rx_ack, rx_full} rx_state_e;
	typedef enum logic [1:0] {tx_idle, tx_req, tx_wait_low} tx_state_e;

endpackage

// ==== logic/exu_req_rx.sv ====
/*
 * input side of the execute unit
 *   four-phase req/ack receiver FSM
 *   one-entry operation buffer with valid/ready release
 */
`timescale 1ns/10ps

module exu_req_rx (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_req,
	input  exu_pkg::op_class_e  in_class,
	input  exu_pkg::funct3_t    in_funct3,
	input  logic                in_funct7_b5,
	input  exu_pkg::word_t      in_rs1,
	input  exu_pkg::word_t      in_rs2,
	input  exu_pkg::word_t      in_imm,
	output logic                in_ack,
	output exu_pkg::op_class_e  op_class,
	output exu_pkg::funct3_t    op_funct3,
	output logic                op_funct7_b5,
	output exu_pkg::word_t      op_rs1,
	output exu_pkg::word_t      op_rs2,
	output exu_pkg::word_t      op_imm,
	output logic                op_valid,
	input  logic                op_ready
);

	exu_pkg::rx_state_e state;
	logic load;
	logic xfer;

	// item leaves for the processing part
	assign xfer = op_valid && op_ready;
	// take a new operation only into an empty buffer and before it is acked
	assign load = in_req && !op_valid
		&& (state == exu_pkg::rx_idle || state == exu_pkg::rx_full);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= exu_pkg::rx_idle;
			in_ack <= 1'b0;
			op_valid <= 1'b0;
		end else begin
			case (state)
				exu_pkg::rx_idle, exu_pkg::rx_full: begin
					if (load) begin
						in_ack <= 1'b1;
						state <= exu_pkg::rx_ack;
					end else if (in_req) begin
						// buffer still occupied, ack withheld
						state <= exu_pkg::rx_full;
					end else begin
						state <= exu_pkg::rx_idle;
					end
				end
				exu_pkg::rx_ack: begin
					// return to zero once the sender lets go
					if (!in_req) begin
						in_ack <= 1'b0;
						state <= exu_pkg::rx_idle;
					end
				end
				default: state <= exu_pkg::rx_idle;
			endcase
			// buffer valid, load and xfer never coincide
			if (load)
				op_valid <= 1'b1;
			else if (xfer)
				op_valid <= 1'b0;
		end
	end

	// payload buffer
	always_ff @(posedge clk) begin
		if (load) begin
			op_class <= in_class;
			op_funct3 <= in_funct3;
			op_funct7_b5 <= in_funct7_b5;
			op_rs1 <= in_rs1;
			op_rs2 <= in_rs2;
			op_imm <= in_imm;
		end
	end

	// a stalled operation keeps its fields until tx takes it
	a_hold: assert property (@(posedge clk) disable iff (rst)
		op_valid && !op_ready |=> op_valid && $stable(op_rs1) && $stable(op_rs2)
			&& $stable(op_imm) && $stable(op_class) && $stable(op_funct3)
			&& $stable(op_funct7_b5));
	// ack only answers a request that is still up
	a_ack: assert property (@(posedge clk) disable iff (rst)
		$rose(in_ack) |-> $past(in_req) && in_req);

endmodule

// ==== logic/exu_decode.sv ====
/*
 * RV32I field decode
 *   instruction class, funct3 and funct7 bit 5 to ALU code
 *   second operand select and branch condition
 */
`timescale 1ns/10ps

module exu_decode (
	input  exu_pkg::op_class_e  op_class,
	input  exu_pkg::funct3_t    op_funct3,
	input  logic                op_funct7_b5,
	output exu_pkg::alu_op_e    alu_op,
	output logic                use_imm,
	output exu_pkg::br_cond_e   br_cond
);

	logic is_reg;

	// sub exists only in register form, addi has no funct7
	assign is_reg = (op_class == exu_pkg::cls_reg);

	always_comb begin
		// unused encodings fall back to add, never taken
		alu_op = exu_pkg::alu_add;
		use_imm = 1'b0;
		br_cond = exu_pkg::br_none;
		case (op_class)
			exu_pkg::cls_reg, exu_pkg::cls_imm: begin
				use_imm = !is_reg;
				case (op_funct3)
					exu_pkg::f3_add_sub:
						alu_op = (is_reg && op_funct7_b5) ? exu_pkg::alu_sub : exu_pkg::alu_add;
					exu_pkg::f3_sll:
						alu_op = exu_pkg::alu_sll;
					exu_pkg::f3_slt:
						alu_op = exu_pkg::alu_slt;
					exu_pkg::f3_sltu:
						alu_op = exu_pkg::alu_sltu;
					exu_pkg::f3_xor:
						alu_op = exu_pkg::alu_xor;
					// srai keeps funct7 bit 5 in the immediate, so both classes use it
					exu_pkg::f3_srl_sra:
						alu_op = op_funct7_b5 ? exu_pkg::alu_sra : exu_pkg::alu_srl;
					exu_pkg::f3_or:
						alu_op = exu_pkg::alu_or;
					exu_pkg::f3_and:
						alu_op = exu_pkg::alu_and;
					default:
						alu_op = exu_pkg::alu_add;
				endcase
			end
			exu_pkg::cls_lui: begin
				// immediate arrives already shifted, pass it through
				alu_op = exu_pkg::alu_pass;
				use_imm = 1'b1;
			end
			exu_pkg::cls_branch: begin
				case (op_funct3)
					// equality via the zero flag of a subtract
					exu_pkg::f3_beq: begin
						alu_op = exu_pkg::alu_sub;
						br_cond = exu_pkg::br_eq;
					end
					exu_pkg::f3_bne: begin
						alu_op = exu_pkg::alu_sub;
						br_cond = exu_pkg::br_ne;
					end
					// ordering via bit 0 of the set-less-than result
					exu_pkg::f3_blt: begin
						alu_op = exu_pkg::alu_slt;
						br_cond = exu_pkg::br_lt;
					end
					exu_pkg::f3_bge: begin
						alu_op = exu_pkg::alu_slt;
						br_cond = exu_pkg::br_ge;
					end
					exu_pkg::f3_bltu: begin
						alu_op = exu_pkg::alu_sltu;
						br_cond = exu_pkg::br_ltu;
					end
					exu_pkg::f3_bgeu: begin
						alu_op = exu_pkg::alu_sltu;
						br_cond = exu_pkg::br_geu;
					end
					default: br_cond = exu_pkg::br_none;
				endcase
			end
			default: alu_op = exu_pkg::alu_add;
		endcase
	end

endmodule

// ==== logic/exu_alu.sv ====
/*
 * combinational ALU
 *   add, sub, slt, sltu, xor, or, and, pass src2
 *   sll, srl, sra with a masked shift amount
 *   zero flag on the result
 */
`timescale 1ns/10ps

module exu_alu (
	input  exu_pkg::word_t    src1,
	input  exu_pkg::word_t    src2,
	input  exu_pkg::alu_op_e  alu_op,
	output exu_pkg::word_t    result,
	output logic              zero
);

	// one extra bit on top catches the carry out
	logic [exu_pkg::xlen:0] diff;
	logic [exu_pkg::shamt_bits-1:0] shamt;
	logic lt_u;
	logic lt_s;
	logic sign_differs;

	// src1 - src2 as src1 + ~src2 + 1
	assign diff = {1'b0, src1} + {1'b0, ~src2} + 1'b1;

	// no carry out means a borrow, so src1 < src2 unsigned
	assign lt_u = ~diff[exu_pkg::xlen];

	// with mixed signs the negative one is smaller
	// with equal signs the difference cannot overflow, its sign decides
	assign sign_differs = src1[exu_pkg::xlen-1] ^ src2[exu_pkg::xlen-1];
	assign lt_s = sign_differs ? src1[exu_pkg::xlen-1] : diff[exu_pkg::xlen-1];

	// RV32I uses only the low five bits as shift amount
	assign shamt = src2[exu_pkg::shamt_bits-1:0];

	always_comb begin
		case (alu_op)
			exu_pkg::alu_add:
				result = src1 + src2;
			exu_pkg::alu_sub:
				result = diff[exu_pkg::xlen-1:0];
			exu_pkg::alu_slt:
				result = {{(exu_pkg::xlen-1){1'b0}}, lt_s};
			exu_pkg::alu_sltu:
				result = {{(exu_pkg::xlen-1){1'b0}}, lt_u};
			exu_pkg::alu_xor:
				result = src1 ^ src2;
			exu_pkg::alu_or:
				result = src1 | src2;
			exu_pkg::alu_and:
				result = src1 & src2;
			// lui, immediate already sits in the upper bits
			exu_pkg::alu_pass:
				result = src2;
			exu_pkg::alu_srl:
				result = src1 >> shamt;
			exu_pkg::alu_sll:
				result = src1 << shamt;
			// arithmetic shift, sign bit fills from the left
			exu_pkg::alu_sra:
				result = $signed(src1) >>> shamt;
			default:
				result = '0;
		endcase
	end

	// beq/bne look at this after a subtract
	assign zero = (result == '0);

endmodule

// ==== logic/exu_resp_tx.sv ====
/*
 * output side of the execute unit
 *   branch-taken resolution from zero flag and compare bit
 *   one-entry result register
 *   four-phase req/ack sender FSM
 */
`timescale 1ns/10ps

module exu_resp_tx (
	input  logic               clk,
	input  logic               rst,
	input  logic               op_valid,
	output logic               op_ready,
	input  exu_pkg::word_t     result,
	input  logic               zero,
	input  exu_pkg::br_cond_e  br_cond,
	output logic               out_req,
	input  logic               out_ack,
	output exu_pkg::word_t     out_result,
	output logic               out_taken
);

	exu_pkg::tx_state_e state;
	logic xfer;
	logic taken;

	// free only once the last handshake is fully back at zero
	assign op_ready = (state == exu_pkg::tx_idle);
	assign xfer = op_valid && op_ready;

	// branch decision, compares leave their answer in result bit 0
	always_comb begin
		case (br_cond)
			exu_pkg::br_eq:
				taken = zero;
			exu_pkg::br_ne:
				taken = !zero;
			exu_pkg::br_lt, exu_pkg::br_ltu:
				taken = result[0];
			exu_pkg::br_ge, exu_pkg::br_geu:
				taken = !result[0];
			default:
				taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= exu_pkg::tx_idle;
			out_req <= 1'b0;
		end else begin
			case (state)
				exu_pkg::tx_idle: begin
					if (xfer)
						state <= exu_pkg::tx_req;
				end
				exu_pkg::tx_req: begin
					// raise req a cycle after the load, data is settled by then
					if (!out_req) begin
						out_req <= 1'b1;
					end else if (out_ack) begin
						out_req <= 1'b0;
						state <= exu_pkg::tx_wait_low;
					end
				end
				exu_pkg::tx_wait_low: begin
					// receiver must drop ack before the next item
					if (!out_ack)
						state <= exu_pkg::tx_idle;
				end
				default: state <= exu_pkg::tx_idle;
			endcase
		end
	end

	// result register
	always_ff @(posedge clk) begin
		if (xfer) begin
			out_result <= result;
			out_taken <= taken;
		end
	end

	// receiver may sample data any time req is up
	a_stable: assert property (@(posedge clk) disable iff (rst)
		out_req |=> !out_req || ($stable(out_result) && $stable(out_taken)));

endmodule

// ==== logic/exu_top.sv ====
/*
 * execute unit top level
 *   four-phase receiver, field decoder, ALU, four-phase sender
 *   second operand select between rs2 and immediate
 */
`timescale 1ns/10ps

module exu_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_req,
	input  exu_pkg::op_class_e  in_class,
	input  exu_pkg::funct3_t    in_funct3,
	input  logic                in_funct7_b5,
	input  exu_pkg::word_t      in_rs1,
	input  exu_pkg::word_t      in_rs2,
	input  exu_pkg::word_t      in_imm,
	output logic                in_ack,
	output logic                out_req,
	input  logic                out_ack,
	output exu_pkg::word_t      out_result,
	output logic                out_taken
);

	// held operation, rx to tx
	exu_pkg::op_class_e op_class;
	exu_pkg::funct3_t op_funct3;
	logic op_funct7_b5;
	exu_pkg::word_t op_rs1;
	exu_pkg::word_t op_rs2;
	exu_pkg::word_t op_imm;
	logic op_valid;
	logic op_ready;

	// decode and ALU outputs
	exu_pkg::alu_op_e alu_op;
	logic use_imm;
	exu_pkg::br_cond_e br_cond;
	exu_pkg::word_t src2;
	exu_pkg::word_t result;
	logic zero;

	exu_req_rx u_req_rx (
		.clk(clk), .rst(rst),
		.in_req(in_req), .in_class(in_class), .in_funct3(in_funct3),
		.in_funct7_b5(in_funct7_b5), .in_rs1(in_rs1), .in_rs2(in_rs2),
		.in_imm(in_imm), .in_ack(in_ack),
		.op_class(op_class), .op_funct3(op_funct3), .op_funct7_b5(op_funct7_b5),
		.op_rs1(op_rs1), .op_rs2(op_rs2), .op_imm(op_imm),
		.op_valid(op_valid), .op_ready(op_ready)
	);

	exu_decode u_decode (
		.op_class(op_class), .op_funct3(op_funct3), .op_funct7_b5(op_funct7_b5),
		.alu_op(alu_op), .use_imm(use_imm), .br_cond(br_cond)
	);

	// immediate forms and lui replace rs2
	assign src2 = use_imm ? op_imm : op_rs2;

	exu_alu u_alu (
		.src1(op_rs1), .src2(src2), .alu_op(alu_op),
		.result(result), .zero(zero)
	);

	exu_resp_tx u_resp_tx (
		.clk(clk), .rst(rst),
		.op_valid(op_valid), .op_ready(op_ready),
		.result(result), .zero(zero), .br_cond(br_cond),
		.out_req(out_req), .out_ack(out_ack),
		.out_result(out_result), .out_taken(out_taken)
	);

endmodule

// ==== verification/exu_tb_model.svh ====
/*
 * testbench helpers for the execute unit
 *   reference model of result and branch-taken flag
 *   value compare with mismatch report
 *   input-link and output-link four-phase driver tasks
 */
`ifndef EXU_TB_MODEL_SVH
`define EXU_TB_MODEL_SVH

// expected result straight from the RV32I rules
function automatic void model_exec(input exu_pkg::op_class_e cls, input logic [2:0] f3,
	input logic f7, input logic [31:0] rs1, input logic [31:0] rs2, input logic [31:0] imm,
	output logic [31:0] res, output logic taken);
	logic [31:0] b;
	// immediate and lui forms ignore rs2
	b = (cls == exu_pkg::cls_reg) ? rs2 : imm;
	res = 32'd0;
	taken = 1'b0;
	if (cls == exu_pkg::cls_lui) begin
		res = imm;
	end else if (cls == exu_pkg::cls_branch) begin
		case (f3)
			3'd0: taken = (rs1 == rs2);
			3'd1: taken = (rs1 != rs2);
			3'd4: taken = ($signed(rs1) < $signed(rs2));
			3'd5: taken = ($signed(rs1) >= $signed(rs2));
			3'd6: taken = (rs1 < rs2);
			3'd7: taken = (rs1 >= rs2);
			default: taken = 1'b0;
		endcase
		// beq/bne subtract, signed and unsigned compares give 0 or 1
		if (f3[2:1] == 2'b10)
			res = {31'd0, $signed(rs1) < $signed(rs2)};
		else if (f3[2:1] == 2'b11)
			res = {31'd0, rs1 < rs2};
		else if (f3[2:1] == 2'b00)
			res = rs1 - rs2;
		else
			res = rs1 + rs2;
	end else begin
		case (f3)
			3'd0: res = (f7 && cls == exu_pkg::cls_reg) ? rs1 - b : rs1 + b;
			3'd1: res = rs1 << b[4:0];
			3'd2: res = {31'd0, $signed(rs1) < $signed(b)};
			3'd3: res = {31'd0, rs1 < b};
			3'd4: res = rs1 ^ b;
			3'd6: res = rs1 | b;
			3'd7: res = rs1 & b;
			default: begin
				// funct7 bit 5 picks arithmetic shift in both classes
				if (f7)
					res = $signed(rs1) >>> b[4:0];
				else
					res = rs1 >> b[4:0];
			end
		endcase
	end
endfunction

task automatic check_val(input string name, input logic [31:0] actual,
	input logic [31:0] expected);
	if (actual !== expected) begin
		$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at first mismatch");
	end
endtask

// queue the expected response, then raise req with the fields
task automatic start_op(input exu_pkg::op_class_e cls, input logic [2:0] f3, input logic f7,
	input logic [31:0] rs1, input logic [31:0] rs2, input logic [31:0] imm);
	logic [31:0] res;
	logic taken;
	model_exec(cls, f3, f7, rs1, rs2, imm, res, taken);
	exp_res_q.push_back(res);
	exp_taken_q.push_back(taken);
	@(posedge clk);
	in_class <= cls;
	in_funct3 <= f3;
	in_funct7_b5 <= f7;
	in_rs1 <= rs1;
	in_rs2 <= rs2;
	in_imm <= imm;
	in_req <= 1'b1;
endtask

// wait for ack, drop req, wait for ack low
task automatic finish_op();
	@(posedge clk);
	while (!in_ack)
		@(posedge clk);
	in_req <= 1'b0;
	@(posedge clk);
	while (in_ack)
		@(posedge clk);
endtask

task automatic send_op(input exu_pkg::op_class_e cls, input logic [2:0] f3, input logic f7,
	input logic [31:0] rs1, input logic [31:0] rs2, input logic [31:0] imm);
	start_op(cls, f3, f7, rs1, rs2, imm);
	finish_op();
endtask

// take one response, holding ack back for ack_delay cycles
task automatic recv_resp(input int ack_delay);
	logic [31:0] exp_res;
	logic exp_taken;
	@(posedge clk);
	while (!out_req)
		@(posedge clk);
	if (exp_res_q.size() == 0) begin
		$display("Response at %0t ns arrived with no operation outstanding", $time);
		$display("SOME TESTS FAILED");
		$fatal(1, "unexpected response");
	end else begin
		exp_res = exp_res_q.pop_front();
		exp_taken = exp_taken_q.pop_front();
		check_val("out_result", out_result, exp_res);
		check_val("out_taken", out_taken, exp_taken);
		// result must hold while req waits for ack
		repeat (ack_delay) begin
			@(posedge clk);
			check_val("out_req", out_req, 1'b1);
			check_val("out_result", out_result, exp_res);
		end
		out_ack <= 1'b1;
		@(posedge clk);
		while (out_req)
			@(posedge clk);
		out_ack <= 1'b0;
	end
endtask

`endif

// ==== verification/exu_tb.sv ====
/*
 * testbench top for the execute unit
 *   clock, reset and watchdog
 *   directed tests for ALU ops, shifts, immediates and branches
 *   back-pressure, ordering and latency checks
 */
`timescale 1ns/10ps

module exu_tb;

	// operations issued by all tests together
	localparam int n_ops = 207;
	localparam int cycles_per_op = 40;
	localparam int clk_period = 20;

	logic clk = 1'b0;
	logic rst;
	logic in_req;
	exu_pkg::op_class_e in_class;
	exu_pkg::funct3_t in_funct3;
	logic in_funct7_b5;
	exu_pkg::word_t in_rs1;
	exu_pkg::word_t in_rs2;
	exu_pkg::word_t in_imm;
	logic in_ack;
	logic out_req;
	logic out_ack;
	exu_pkg::word_t out_result;
	logic out_taken;

	integer seed = 32'hb8b1_0e68;
	// expected responses in issue order
	exu_pkg::word_t exp_res_q[$];
	logic exp_taken_q[$];

	`include "exu_tb_model.svh"

	exu_top u_exu_top (
		.clk(clk), .rst(rst),
		.in_req(in_req), .in_class(in_class), .in_funct3(in_funct3),
		.in_funct7_b5(in_funct7_b5), .in_rs1(in_rs1), .in_rs2(in_rs2),
		.in_imm(in_imm), .in_ack(in_ack),
		.out_req(out_req), .out_ack(out_ack),
		.out_result(out_result), .out_taken(out_taken)
	);

	always #(clk_period / 2) clk = ~clk;

	// one operation start to finish, ack given at once
	task automatic run_op(input exu_pkg::op_class_e cls, input logic [2:0] f3, input logic f7,
		input logic [31:0] rs1, input logic [31:0] rs2, input logic [31:0] imm);
		send_op(cls, f3, f7, rs1, rs2, imm);
		recv_resp(0);
	endtask

	// add, sub, slt, sltu, xor, or, and on one operand pair
	task automatic reg_ops_on_pair(input logic [31:0] a, input logic [31:0] b);
		for (int f = 0; f < 8; f++) begin
			if (f == 1 || f == 5)
				continue;
			run_op(exu_pkg::cls_reg, 3'(f), 1'b0, a, b, ~b);
		end
		run_op(exu_pkg::cls_reg, 3'd0, 1'b1, a, b, ~b);
	endtask

	task automatic reg_class_ops();
		exu_pkg::word_t corners [3] = '{32'h0, 32'hffff_ffff, 32'h8000_0000};
		exu_pkg::word_t a;
		exu_pkg::word_t b;
		for (int i = 0; i < 3; i++)
			for (int j = 0; j < 3; j++)
				reg_ops_on_pair(corners[i], corners[j]);
		repeat (4) begin
			a = $random(seed);
			b = $random(seed);
			reg_ops_on_pair(a, b);
		end
	endtask

	// amounts above 31 only move by their low five bits
	task automatic shift_masking();
		exu_pkg::word_t vals [2] = '{32'h8000_0001, 32'h7ff0_000f};
		exu_pkg::word_t amts [4] = '{32'd1, 32'd31, 32'd32, 32'hffff_ffe3};
		for (int v = 0; v < 2; v++) begin
			for (int s = 0; s < 4; s++) begin
				run_op(exu_pkg::cls_reg, 3'd1, 1'b0, vals[v], amts[s], 32'd0);
				run_op(exu_pkg::cls_reg, 3'd5, 1'b0, vals[v], amts[s], 32'd0);
				run_op(exu_pkg::cls_reg, 3'd5, 1'b1, vals[v], amts[s], 32'd0);
				run_op(exu_pkg::cls_imm, 3'd1, 1'b0, vals[v], 32'hdead_beef, amts[s]);
				run_op(exu_pkg::cls_imm, 3'd5, 1'b0, vals[v], 32'hdead_beef, amts[s]);
				run_op(exu_pkg::cls_imm, 3'd5, 1'b1, vals[v], 32'hdead_beef, amts[s]);
			end
		end
	endtask

	task automatic imm_and_lui();
		exu_pkg::word_t a;
		exu_pkg::word_t imm;
		for (int k = 0; k < 2; k++) begin
			a = $random(seed);
			imm = k ? 32'hffff_f800 : 32'h0000_07ff;
			for (int f = 0; f < 8; f++) begin
				if (f == 1 || f == 5)
					continue;
				run_op(exu_pkg::cls_imm, 3'(f), 1'b0, a, 32'hdead_beef, imm);
			end
		end
		// addi has no subtract form
		run_op(exu_pkg::cls_imm, 3'd0, 1'b1, a, 32'hdead_beef, imm);
		run_op(exu_pkg::cls_lui, 3'd0, 1'b0, a, 32'hdead_beef, 32'h1234_5000);
		run_op(exu_pkg::cls_lui, 3'd0, 1'b0, a, 32'hdead_beef, 32'hffff_f000);
		run_op(exu_pkg::cls_lui, 3'd0, 1'b0, a, 32'hdead_beef, 32'h0);
	endtask

	// pairs give each condition a taken and a not-taken case
	task automatic branch_conditions();
		exu_pkg::word_t lhs [6] = '{32'd5, 32'd5, 32'd7, 32'hffff_ffff, 32'd1, 32'h8000_0000};
		exu_pkg::word_t rhs [6] = '{32'd5, 32'd7, 32'd5, 32'd1, 32'hffff_ffff, 32'h7fff_ffff};
		for (int p = 0; p < 6; p++) begin
			for (int f = 0; f < 8; f++) begin
				if (f == 2 || f == 3)
					continue;
				run_op(exu_pkg::cls_branch, 3'(f), 1'b0, lhs[p], rhs[p], 32'h0000_0ff0);
			end
		end
	endtask

	// first item stalls in tx, second in rx, third gets no ack
	task automatic backpressure_hold();
		send_op(exu_pkg::cls_reg, 3'd0, 1'b0, $random(seed), 32'd11, 32'd0);
		send_op(exu_pkg::cls_reg, 3'd4, 1'b0, 32'h0f0f_0f0f, 32'd22, 32'd0);
		start_op(exu_pkg::cls_reg, 3'd0, 1'b1, 32'd100, 32'd33, 32'd0);
		repeat (6) begin
			@(posedge clk);
			check_val("in_ack", in_ack, 1'b0);
			check_val("out_req", out_req, 1'b1);
		end
		fork
			finish_op();
			begin
				recv_resp(2);
				recv_resp(0);
				recv_resp(0);
			end
		join
	endtask

	// back to back sends against a receiver with random ack delays
	task automatic delayed_ack_stream();
		exu_pkg::word_t sa [12];
		exu_pkg::word_t sb [12];
		logic [3:0] sf [12];
		int dly [12];
		for (int i = 0; i < 12; i++) begin
			sa[i] = $random(seed);
			sb[i] = $random(seed);
			sf[i] = $random(seed);
			dly[i] = $random(seed) & 7;
		end
		fork
			for (int i = 0; i < 12; i++)
				send_op(exu_pkg::cls_reg, sf[i][2:0], sf[i][3], sa[i], sb[i], 32'd0);
			for (int i = 0; i < 12; i++)
				recv_resp(dly[i]);
		join
	endtask

	task automatic unstalled_latency();
		int n;
		start_op(exu_pkg::cls_reg, 3'd0, 1'b0, 32'd3, 32'd4, 32'd0);
		// this edge samples in_req high
		@(posedge clk);
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!out_req && n < 10);
		check_val("out_req latency in cycles", n, 3);
		finish_op();
		recv_resp(0);
	endtask

	initial begin
		rst = 1'b1;
		in_req = 1'b0;
		in_class = exu_pkg::cls_reg;
		in_funct3 = 3'd0;
		in_funct7_b5 = 1'b0;
		in_rs1 = 32'd0;
		in_rs2 = 32'd0;
		in_imm = 32'd0;
		out_ack = 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check_val("out_req", out_req, 1'b0);
		check_val("in_ack", in_ack, 1'b0);
		reg_class_ops();
		shift_masking();
		imm_and_lui();
		branch_conditions();
		backpressure_hold();
		delayed_ack_stream();
		unstalled_latency();
		$display("ALL TESTS PASSED");
		$finish;
	end

	// watchdog
	initial begin
		#(n_ops * cycles_per_op * clk_period + 10 * clk_period);
		$display("Timeout at %0t ns, the tests did not finish in time", $time);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== tb.f ====
+incdir+verification
logic/exu_pkg.sv
logic/exu_req_rx.sv
logic/exu_decode.sv
logic/exu_alu.sv
logic/exu_resp_tx.sv
logic/exu_top.sv
verification/exu_tb.sv
